// File: cpu_pkg.sv
// ======================================
// Memory side shared types
// ======================================
`default_nettype none

package cpu_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // load/store tag, same width as the rob nick
    localparam int NICK_W = 4;

    // mem_a[17:16] value of the uart and timer window
    localparam logic [1:0] IO_SEL = 2'b11;

    typedef enum logic [1:0] {
        LEN_1,
        LEN_2,
        LEN_4
    } len_e;

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } ls_op_e;

    typedef enum logic [1:0] {
        MC_IDLE,
        MC_READ,
        MC_WRITE
    } mc_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [DATA_W-1:0] inst;
    } inst_t;

    typedef struct packed {
        ls_op_e            op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [NICK_W-1:0] nick;
    } ls_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [NICK_W-1:0] nick;
    } ls_resp_t;

    // one transfer for memctrl
    typedef struct packed {
        logic              wr;
        len_e              len;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } mc_req_t;

    function automatic logic is_io(input logic [ADDR_W-1:0] addr);
        return addr[17:16] == IO_SEL;
    endfunction

endpackage

`default_nettype wire

// File: mc_arbiter.sv
// ======================================
// Memory port arbiter
// ======================================
`default_nettype none

module mc_arbiter (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  logic             dc_req_valid,
    input  cpu_pkg::mc_req_t dc_req,
    output logic             dc_done,
    input  logic             if_req_valid,
    input  cpu_pkg::mc_req_t if_req,
    output logic             if_done,
    output logic             mc_valid,
    input  logic             mc_ready,
    output cpu_pkg::mc_req_t mc_req,
    input  logic             mc_done
);

    // grant held from acceptance until done
    logic busy;
    logic own_dc;
    logic sel_dc;

    // load/store port wins a tie
    assign sel_dc   = busy ? own_dc : dc_req_valid;
    assign mc_valid = !busy && (dc_req_valid || if_req_valid);
    assign mc_req   = sel_dc ? dc_req : if_req;

    // done goes back to whoever holds the grant
    assign dc_done = mc_done && busy && own_dc;
    assign if_done = mc_done && busy && !own_dc;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            own_dc <= 1'b0;
        end else if (rdy) begin
            if (mc_valid && mc_ready) begin
                busy   <= 1'b1;
                own_dc <= sel_dc;
            end else if (mc_done) begin
                busy <= 1'b0;
            end
        end
    end

    // memctrl only finishes transfers that were granted here
    a_done_one_owner: assert property (@(posedge clk) disable iff (rst)
        mc_done |-> $onehot({dc_done, if_done}));

endmodule

`default_nettype wire

// File: memctrl.sv
// ======================================
// Byte-serial memory controller
// ======================================
`default_nettype none

module memctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  logic             io_buffer_full,
    input  logic [7:0]       mem_din,
    output logic [7:0]       mem_dout,
    output logic [31:0]      mem_a,
    output logic             mem_wr,
    input  logic             req_valid,
    output logic             req_ready,
    input  cpu_pkg::mc_req_t req,
    output logic             done,
    output logic [31:0]      rdata
);
    import cpu_pkg::*;

    mc_state_e state;

    // latched request
    logic [ADDR_W-1:0] base;
    logic [DATA_W-1:0] wdata;
    logic [2:0]        nbytes;
    logic              io_wr;

    // issue counter runs one cycle ahead of capture
    logic [2:0] icnt;
    logic [2:0] ccnt;
    logic       cap_on;

    logic       req_io;
    logic [2:0] req_n;
    logic       accept;
    logic       wr_go;
    logic       capture;

    function automatic logic [2:0] len_bytes(input len_e len);
        case (len)
            LEN_1:   return 3'd1;
            LEN_2:   return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    assign req_io = is_io(req.addr);
    // uart reads are one byte
    assign req_n  = (req_io && !req.wr) ? 3'd1 : len_bytes(req.len);

    assign req_ready = (state == MC_IDLE) && !done;
    assign accept    = rdy && req_valid && req_ready;
    assign wr_go     = rdy && (state == MC_WRITE) && !(io_wr && io_buffer_full);
    assign capture   = rdy && (state == MC_READ) && cap_on;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= MC_IDLE;
            mem_a  <= '0;
            mem_wr <= 1'b0;
            done   <= 1'b0;
            icnt   <= '0;
            ccnt   <= '0;
            cap_on <= 1'b0;
        end else if (rdy) begin
            // bus parks at address 0 when idle so uart input is not consumed
            mem_a  <= '0;
            mem_wr <= 1'b0;
            done   <= 1'b0;
            case (state)
                MC_IDLE: begin
                    if (accept) begin
                        icnt   <= 3'd1;
                        ccnt   <= '0;
                        cap_on <= 1'b0;
                        if (!req.wr) begin
                            state <= MC_READ;
                            mem_a <= req.addr;
                        end else if (req_io && io_buffer_full) begin
                            // uart full, first byte waits
                            state <= MC_WRITE;
                            icnt  <= '0;
                        end else begin
                            mem_a  <= req.addr;
                            mem_wr <= 1'b1;
                            if (req_n == 3'd1) begin
                                done <= 1'b1;
                            end else begin
                                state <= MC_WRITE;
                            end
                        end
                    end
                end
                MC_WRITE: begin
                    if (wr_go) begin
                        mem_a  <= base + ADDR_W'(icnt);
                        mem_wr <= 1'b1;
                        icnt   <= icnt + 3'd1;
                        if (icnt + 3'd1 == nbytes) begin
                            done  <= 1'b1;
                            state <= MC_IDLE;
                        end
                    end
                end
                MC_READ: begin
                    cap_on <= 1'b1;
                    if (icnt < nbytes) begin
                        mem_a <= base + ADDR_W'(icnt);
                        icnt  <= icnt + 3'd1;
                    end
                    if (cap_on) begin
                        ccnt <= ccnt + 3'd1;
                        if (ccnt + 3'd1 == nbytes) begin
                            done  <= 1'b1;
                            state <= MC_IDLE;
                        end
                    end
                end
                default: state <= MC_IDLE;
            endcase
        end
    end

    // request payload, write byte and read assembly
    always_ff @(posedge clk) begin
        if (accept) begin
            base     <= req.addr;
            wdata    <= req.data;
            nbytes   <= req_n;
            io_wr    <= req_io;
            mem_dout <= req.data[7:0];
            rdata    <= '0;
        end else if (wr_go) begin
            mem_dout <= wdata[{icnt[1:0], 3'b000} +: 8];
        end else if (capture) begin
            // little-endian
            rdata[{ccnt[1:0], 3'b000} +: 8] <= mem_din;
        end
    end

    // a read is never mixed with a write strobe
    a_no_wr_in_read: assert property (@(posedge clk) disable iff (rst)
        state == MC_READ |-> !mem_wr);

endmodule

`default_nettype wire

// File: fetcher.sv
// ======================================
// Instruction fetcher
// ======================================
`default_nettype none

module fetcher (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  logic             clr,
    input  logic [31:0]      j_pc,
    output logic             req_valid,
    output cpu_pkg::mc_req_t req,
    input  logic             done,
    input  logic [31:0]      rdata,
    output logic             inst_valid,
    input  logic             inst_ready,
    output cpu_pkg::inst_t   inst
);
    import cpu_pkg::*;

    logic [ADDR_W-1:0] pc;
    // address of the word in flight
    logic [ADDR_W-1:0] fetch_pc;
    // in-flight word belongs to a flushed stream
    logic              drop;
    logic              issue;

    // one outstanding fetch, only into an empty output register
    assign issue = !req_valid && !inst_valid && !clr;

    assign req = '{wr: 1'b0, len: LEN_4, addr: fetch_pc, data: '0};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            req_valid  <= 1'b0;
            drop       <= 1'b0;
            inst_valid <= 1'b0;
        end else if (rdy) begin
            if (done) begin
                req_valid <= 1'b0;
            end else if (issue) begin
                req_valid <= 1'b1;
            end

            if (clr) begin
                pc         <= j_pc;
                inst_valid <= 1'b0;
                drop       <= req_valid && !done;
            end else if (done) begin
                if (drop) begin
                    drop <= 1'b0;
                end else begin
                    inst_valid <= 1'b1;
                    pc         <= fetch_pc + 32'd4;
                end
            end else if (inst_valid && inst_ready) begin
                inst_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issue) begin
            fetch_pc <= pc;
        end
        if (rdy && done && !clr && !drop) begin
            inst.pc   <= fetch_pc;
            inst.inst <= rdata;
        end
    end

endmodule

`default_nettype wire

// File: dcache.sv
// ======================================
// Load/store port
// ======================================
`default_nettype none

module dcache (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              ls_valid,
    output logic              ls_ready,
    input  cpu_pkg::ls_req_t  ls_req,
    output logic              req_valid,
    output cpu_pkg::mc_req_t  req,
    input  logic              done,
    input  logic [31:0]       rdata,
    output logic              resp_valid,
    output cpu_pkg::ls_resp_t resp
);
    import cpu_pkg::*;

    // one request held from acceptance to done
    logic    busy;
    ls_req_t cur;

    function automatic len_e op_len(input ls_op_e op);
        case (op)
            LB, LBU, SB: return LEN_1;
            LH, LHU, SH: return LEN_2;
            default:     return LEN_4;
        endcase
    endfunction

    function automatic logic is_store(input ls_op_e op);
        return op == SB || op == SH || op == SW;
    endfunction

    function automatic logic [DATA_W-1:0] extend(input ls_op_e op, input logic [DATA_W-1:0] d);
        case (op)
            LB:      return {{24{d[7]}}, d[7:0]};
            LH:      return {{16{d[15]}}, d[15:0]};
            LBU:     return {24'b0, d[7:0]};
            LHU:     return {16'b0, d[15:0]};
            default: return d;
        endcase
    endfunction

    assign ls_ready  = !busy;
    assign req_valid = busy;
    assign req = '{wr: is_store(cur.op), len: op_len(cur.op), addr: cur.addr, data: cur.data};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            resp_valid <= 1'b0;
        end else if (rdy) begin
            resp_valid <= 1'b0;
            if (ls_valid && ls_ready) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
                // stores finish silently
                resp_valid <= !is_store(cur.op);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && ls_valid && ls_ready) begin
            cur <= ls_req;
        end
        if (rdy && done) begin
            resp.data <= extend(cur.op, rdata);
            resp.nick <= cur.nick;
        end
    end

endmodule

`default_nettype wire

// File: cpu_mem.sv
// ======================================
// Memory side top level
// ======================================
`default_nettype none

module cpu_mem (
    input  logic              clk_in,
    input  logic              rst,
    input  logic              rdy_in,
    input  logic [7:0]        mem_din,
    output logic [7:0]        mem_dout,
    output logic [31:0]       mem_a,
    output logic              mem_wr,
    input  logic              io_buffer_full,
    input  logic              clr,
    input  logic [31:0]       j_pc,
    output logic              inst_valid,
    input  logic              inst_ready,
    output cpu_pkg::inst_t    inst,
    input  logic              ls_valid,
    output logic              ls_ready,
    input  cpu_pkg::ls_req_t  ls_req,
    output logic              resp_valid,
    output cpu_pkg::ls_resp_t resp
);
    import cpu_pkg::*;

    logic              if_req_valid;
    mc_req_t           if_req;
    logic              if_done;

    logic              dc_req_valid;
    mc_req_t           dc_req;
    logic              dc_done;

    logic              mc_valid;
    logic              mc_ready;
    mc_req_t           mc_req;
    logic              mc_done;
    // read data fans out to both requesters
    logic [DATA_W-1:0] mc_rdata;

    fetcher u_fetcher (
        .clk        (clk_in),
        .rst        (rst),
        .rdy        (rdy_in),
        .clr        (clr),
        .j_pc       (j_pc),
        .req_valid  (if_req_valid),
        .req        (if_req),
        .done       (if_done),
        .rdata      (mc_rdata),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst)
    );

    dcache u_dcache (
        .clk        (clk_in),
        .rst        (rst),
        .rdy        (rdy_in),
        .ls_valid   (ls_valid),
        .ls_ready   (ls_ready),
        .ls_req     (ls_req),
        .req_valid  (dc_req_valid),
        .req        (dc_req),
        .done       (dc_done),
        .rdata      (mc_rdata),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    mc_arbiter u_arbiter (
        .clk          (clk_in),
        .rst          (rst),
        .rdy          (rdy_in),
        .dc_req_valid (dc_req_valid),
        .dc_req       (dc_req),
        .dc_done      (dc_done),
        .if_req_valid (if_req_valid),
        .if_req       (if_req),
        .if_done      (if_done),
        .mc_valid     (mc_valid),
        .mc_ready     (mc_ready),
        .mc_req       (mc_req),
        .mc_done      (mc_done)
    );

    memctrl u_memctrl (
        .clk            (clk_in),
        .rst            (rst),
        .rdy            (rdy_in),
        .io_buffer_full (io_buffer_full),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .req_valid      (mc_valid),
        .req_ready      (mc_ready),
        .req            (mc_req),
        .done           (mc_done),
        .rdata          (mc_rdata)
    );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
// ======================================
// Byte memory model
// ======================================
`default_nettype none

module tb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        rdy,
    input  logic [31:0] mem_a,
    input  logic [7:0]  mem_dout,
    input  logic        mem_wr,
    output logic [7:0]  mem_din,
    output logic        io_buffer_full,
    output int          pause_errors
);
    import cpu_pkg::*;

    // 128 KB ram behind the bus
    logic [7:0]  mem [0:131071];
    // bytes written to the uart
    logic [7:0]  io_out [$];
    logic        prev_rdy;
    logic [31:0] prev_a;

    task automatic preload();
        for (int a = 0; a < 131072; a++) begin
            mem[17'(a)] = 8'($urandom);
        end
    endtask

    // uart full in random bursts
    initial begin
        io_buffer_full = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if ($urandom % 8 == 0) begin
                io_buffer_full = !io_buffer_full;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            mem_din      <= '0;
            pause_errors <= 0;
            prev_rdy     <= 1'b1;
            prev_a       <= '0;
        end else begin
            if (!prev_rdy && mem_a != prev_a) begin
                $display("mem_a moved from %h to %h while rdy_in was low, time %0t",
                         prev_a, mem_a, $time);
                pause_errors <= pause_errors + 1;
            end
            prev_rdy <= rdy;
            prev_a   <= mem_a;
            if (rdy) begin
                // read data lands one cycle after the address
                mem_din <= mem[mem_a[16:0]];
                if (mem_wr && mem_a[17:16] == IO_SEL) begin
                    if (mem_dout != 8'h00) begin
                        io_out.push_back(mem_dout);
                    end
                end else if (mem_wr) begin
                    mem[mem_a[16:0]] = mem_dout;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_top.sv
// ======================================
// Memory side testbench
// ======================================
`default_nettype none

module tb_top;
    import cpu_pkg::*;

    localparam int OPS            = 400;
    localparam int OP_CYCLES      = 50;
    localparam int TIMEOUT_CYCLES = OPS * OP_CYCLES;
    localparam int MEM_BYTES      = 131072;

    logic        clk_in;
    logic        rst;
    logic        rdy_in;
    logic [7:0]  mem_din;
    logic [7:0]  mem_dout;
    logic [31:0] mem_a;
    logic        mem_wr;
    logic        io_buffer_full;
    logic        clr;
    logic [31:0] j_pc;
    logic        inst_valid;
    logic        inst_ready;
    inst_t       inst;
    logic        ls_valid;
    logic        ls_ready;
    ls_req_t     ls_req;
    logic        resp_valid;
    ls_resp_t    resp;
    int          pause_errors;

    // shadow of the ram and the expected outputs
    logic [7:0]  shadow [0:MEM_BYTES-1];
    ls_resp_t    exp_resp [$];
    logic [7:0]  exp_io [$];
    logic [31:0] exp_pc = '0;
    logic [3:0]  nick = '0;
    int          errors = 0;
    int          fetched = 0;
    int          redirects = 0;
    int          cycles = 0;

    cpu_mem i_dut (.*);

    tb_mem_model i_mem (
        .clk            (clk_in),
        .rst            (rst),
        .rdy            (rdy_in),
        .mem_a          (mem_a),
        .mem_dout       (mem_dout),
        .mem_wr         (mem_wr),
        .mem_din        (mem_din),
        .io_buffer_full (io_buffer_full),
        .pause_errors   (pause_errors)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // little-endian word from the shadow
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [16:0] a;
        a = addr[16:0];
        return {shadow[a + 17'd3], shadow[a + 17'd2], shadow[a + 17'd1], shadow[a]};
    endfunction

    function automatic logic [31:0] expect_load(input ls_op_e op, input logic [31:0] addr);
        logic [31:0] w;
        w = word_at(addr);
        case (op)
            LB:      return {{24{w[7]}}, w[7:0]};
            LH:      return {{16{w[15]}}, w[15:0]};
            LBU:     return {24'h0, w[7:0]};
            LHU:     return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    // hold the request until accepted, then record what it should do
    task automatic send_ls(input ls_op_e op, input logic [31:0] addr, input logic [31:0] data);
        ls_resp_t e;
        int       nbytes;
        nbytes   = (op == SB) ? 1 : (op == SH) ? 2 : 4;
        ls_req   = '{op: op, addr: addr, data: data, nick: nick};
        ls_valid = 1'b1;
        do begin
            @(posedge clk_in);
        end while (!(rdy_in && ls_ready));
        if (op inside {LB, LH, LW, LBU, LHU}) begin
            e.data = expect_load(op, addr);
            e.nick = nick;
            exp_resp.push_back(e);
        end else if (addr[17:16] == IO_SEL) begin
            // the uart drops zero bytes
            if (data[7:0] != 8'h00) begin
                exp_io.push_back(data[7:0]);
            end
        end else begin
            for (int k = 0; k < nbytes; k++) begin
                shadow[17'(addr + 32'(k))] = 8'(data >> (8 * k));
            end
        end
        nick = nick + 4'd1;
        #1;
        ls_valid = 1'b0;
    endtask

    // rdy_in pauses, fetch back-pressure and redirects
    initial begin
        rdy_in     = 1'b1;
        clr        = 1'b0;
        j_pc       = '0;
        inst_ready = 1'b0;
        @(negedge rst);
        forever begin
            rdy_in = ($urandom % 5) != 0;
            clr    = ($urandom % 40) == 0;
            if (clr) begin
                j_pc       = ($urandom % 32'h8000) & 32'hffff_fffc;
                inst_ready = 1'b0;
            end else begin
                inst_ready = ($urandom % 4) != 0;
            end
            @(posedge clk_in);
            #1;
        end
    end

    always @(posedge clk_in) begin : compare_outputs
        ls_resp_t e;
        if (!rst && rdy_in) begin
            if (clr) begin
                exp_pc = j_pc;
                redirects++;
            end else if (inst_valid && inst_ready) begin
                check_value(inst.pc, exp_pc, "fetch pc");
                check_value(inst.inst, word_at(exp_pc), "fetch word");
                exp_pc = exp_pc + 32'd4;
                fetched++;
            end
            if (resp_valid && exp_resp.size() == 0) begin
                errors++;
                $display("load response at time %0t with no load outstanding", $time);
            end else if (resp_valid) begin
                e = exp_resp.pop_front();
                check_value(resp.data, e.data, "load data");
                check_value(32'(resp.nick), 32'(e.nick), "load nick");
            end
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            cycles++;
        end
        $display("timeout: the run did not finish");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        ls_op_e      op;
        logic [31:0] addr;
        logic [31:0] data;
        void'($urandom(32'h3106_582d));
        rst      = 1'b1;
        ls_valid = 1'b0;
        ls_req   = '0;
        i_mem.preload();
        for (int a = 0; a < MEM_BYTES; a++) begin
            shadow[17'(a)] = i_mem.mem[17'(a)];
        end
        repeat (2) @(posedge clk_in);
        #1;
        rst = 1'b0;
        for (int i = 0; i < OPS; i++) begin
            if (i % 10 == 5) begin
                data = ($urandom % 4 == 0) ? 32'd0 : $urandom;
                send_ls(SB, 32'h0003_0000, data);
            end else begin
                // small window so loads often hit earlier stores
                op   = ls_op_e'(3'($urandom));
                addr = 32'h0001_0000 + ($urandom % 256);
                if (op inside {LH, LHU, SH}) begin
                    addr[0] = 1'b0;
                end
                if (op inside {LW, SW}) begin
                    addr[1:0] = 2'b00;
                end
                send_ls(op, addr, $urandom);
            end
        end
        while (exp_resp.size() != 0 || !ls_ready) begin
            @(posedge clk_in);
        end
        check_value(32'(i_mem.io_out.size()), 32'(exp_io.size()), "uart byte count");
        foreach (exp_io[k]) begin
            if (k < i_mem.io_out.size()) begin
                check_value(32'(i_mem.io_out[k]), 32'(exp_io[k]), "uart byte");
            end
        end
        for (int a = 0; a < MEM_BYTES; a++) begin
            check_value(32'(i_mem.mem[17'(a)]), 32'(shadow[17'(a)]), "ram byte");
        end
        if (fetched == 0 || redirects == 0) begin
            errors++;
            $display("the fetch stream never ran or was never redirected");
        end
        $display("closing: %0d check errors, %0d pause errors, %0d fetched, %0d redirects",
                 errors, pause_errors, fetched, redirects);
        if (errors == 0 && pause_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
cpu_pkg.sv
mc_arbiter.sv
memctrl.sv
fetcher.sv
dcache.sv
cpu_mem.sv
tb_mem_model.sv
tb_top.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and scan the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
